//--- logic/exe_pkg.sv
package exe_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int XLEN   = 64;            // Operand and result width
    localparam int TAG_W  = 6;             // Physical register tag
    localparam int WORD_W = 32;            // Width of the W forms
    localparam int PP_W   = XLEN + WORD_W; // 64 x 32 partial product
    localparam int PROD_W = 2 * XLEN;      // Full product

    typedef logic [XLEN-1:0]  xlen_t;
    typedef logic [TAG_W-1:0] tag_t;

    // ----------------------------------------
    // Operations
    // ----------------------------------------
    // Bit 3 marks the multiplier ops
    typedef enum logic [3:0] {
        OP_ADD    = 4'b0000,
        OP_SUB    = 4'b0001,
        OP_AND    = 4'b0010,
        OP_OR     = 4'b0011,
        OP_XOR    = 4'b0100,
        OP_MUL    = 4'b1000,
        OP_MULH   = 4'b1001,
        OP_MULHSU = 4'b1010,
        OP_MULHU  = 4'b1011
    } exe_op_t;

    // One unit result on its way to writeback
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        xlen_t result;
    } wb_t;

    // True for every op handled by the multiplier
    function automatic logic is_mul_op(exe_op_t op);
        return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
    endfunction

    // Multiplies that need the second stage
    function automatic logic is_long_op(exe_op_t op, logic op_32);
        return is_mul_op(op) && !op_32;
    endfunction

endpackage

//--- logic/exe_req_if.sv
`timescale 1ns/100ps

// One decoded request, valid for a single cycle
interface exe_req_if import exe_pkg::*; ();

    logic    valid;
    exe_op_t op;
    logic    op_32;  // Selects the W form
    xlen_t   src1;
    xlen_t   src2;
    tag_t    tag;    // Destination physical register

    modport issue (
        output valid, op, op_32, src1, src2, tag
    );

    modport unit (
        input valid, op, op_32, src1, src2, tag
    );

endinterface

//--- logic/issue_ctrl.sv
`timescale 1ns/100ps

module issue_ctrl import exe_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     kill_i,
    input  logic     issue_valid_i,
    input  exe_op_t  issue_op_i,
    input  logic     issue_op32_i,
    input  xlen_t    issue_src1_i,
    input  xlen_t    issue_src2_i,
    input  tag_t     issue_tag_i,
    output logic     issue_ready_o,
    exe_req_if.issue alu_req,
    exe_req_if.issue mul_req
);

    logic to_mul;   // Op belongs to the multiplier
    logic is_long;  // Op needs both multiplier stages
    logic accept;
    logic long_q;   // Last accepted op was a long multiply

    assign to_mul  = is_mul_op(issue_op_i);
    assign is_long = is_long_op(issue_op_i, issue_op32_i);

    // A short op right behind a long one would meet it at writeback
    assign issue_ready_o = !kill_i && !(long_q && !is_long);
    assign accept        = issue_valid_i && issue_ready_o;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            alu_req.valid <= 1'b0;
            mul_req.valid <= 1'b0;
            long_q        <= 1'b0;
        end else if (kill_i) begin  // Flush
            alu_req.valid <= 1'b0;
            mul_req.valid <= 1'b0;
            long_q        <= 1'b0;
        end else begin
            alu_req.valid <= accept && !to_mul;
            mul_req.valid <= accept && to_mul;
            long_q        <= accept && is_long;
        end
    end

    // Operands go only to the unit that owns the op
    always_ff @(posedge clk_i) begin
        if (accept && !to_mul) begin
            alu_req.op    <= issue_op_i;
            alu_req.op_32 <= issue_op32_i;
            alu_req.src1  <= issue_src1_i;
            alu_req.src2  <= issue_src2_i;
            alu_req.tag   <= issue_tag_i;
        end
        if (accept && to_mul) begin
            mul_req.op    <= issue_op_i;
            mul_req.op_32 <= issue_op32_i;
            mul_req.src1  <= issue_src1_i;
            mul_req.src2  <= issue_src2_i;
            mul_req.tag   <= issue_tag_i;
        end
    end

endmodule

//--- logic/alu_unit.sv
`timescale 1ns/100ps

module alu_unit import exe_pkg::*; (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  logic           kill_i,
    exe_req_if.unit        req_i,
    output wb_t            wb_o
);

    xlen_t res_d;
    logic  word_arith;  // ADDW or SUBW
    logic  valid_q;
    tag_t  tag_q;
    xlen_t res_q;

    assign word_arith = req_i.op_32 && (req_i.op == OP_ADD || req_i.op == OP_SUB);

    always_comb begin
        case (req_i.op)
            OP_ADD:  res_d = req_i.src1 + req_i.src2;
            OP_SUB:  res_d = req_i.src1 - req_i.src2;
            OP_AND:  res_d = req_i.src1 & req_i.src2;
            OP_OR:   res_d = req_i.src1 | req_i.src2;
            OP_XOR:  res_d = req_i.src1 ^ req_i.src2;
            default: res_d = '0;
        endcase

        // W forms keep the low word and sign-extend it
        if (word_arith) begin
            res_d = {{(XLEN-WORD_W){res_d[WORD_W-1]}}, res_d[WORD_W-1:0]};
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else if (kill_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            tag_q <= req_i.tag;
            res_q <= res_d;
        end
    end

    assign wb_o.valid  = valid_q;
    assign wb_o.tag    = tag_q;
    assign wb_o.result = res_q;

endmodule

//--- logic/mul_unit.sv
`timescale 1ns/100ps

module mul_unit import exe_pkg::*; (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  logic           kill_i,
    exe_req_if.unit        req_i,
    output wb_t            wb_o
);

    // Operand signs
    logic              signed1;     // src1 is read as signed
    logic              signed2;     // src2 is read as signed
    logic              neg1;
    logic              neg2;
    xlen_t             src1_mag_d;
    xlen_t             src2_mag_d;

    // Stage one
    logic              s1_valid;
    logic              s1_op32;
    logic              s1_neg;
    logic              s1_high;     // H forms take the upper half
    tag_t              s1_tag;
    xlen_t             src1_mag_q;
    xlen_t             src2_mag_q;
    logic [PP_W-1:0]   pp_lo;
    logic [PP_W-1:0]   pp_hi;
    logic [WORD_W-1:0] word_fix;
    xlen_t             word_res;
    logic              word_valid;

    // Stage two
    logic              s2_valid;
    logic              s2_neg;
    logic              s2_high;
    tag_t              s2_tag;
    logic [PP_W-1:0]   pp_lo_q;
    logic [PP_W-1:0]   pp_hi_q;
    logic [PROD_W-1:0] prod;
    logic [PROD_W-1:0] prod_fix;
    xlen_t             long_res;

    // ----------------------------------------
    // Operand magnitudes
    // ----------------------------------------
    assign signed1 = (req_i.op != OP_MULHU);
    assign signed2 = (req_i.op == OP_MUL) || (req_i.op == OP_MULH);

    // MULW looks at the sign of the low word
    assign neg1 = signed1 && (req_i.op_32 ? req_i.src1[WORD_W-1] : req_i.src1[XLEN-1]);
    assign neg2 = signed2 && (req_i.op_32 ? req_i.src2[WORD_W-1] : req_i.src2[XLEN-1]);

    assign src1_mag_d = neg1 ? ~req_i.src1 + xlen_t'(1) : req_i.src1;
    assign src2_mag_d = neg2 ? ~req_i.src2 + xlen_t'(1) : req_i.src2;

    // ----------------------------------------
    // Stage one
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_valid <= 1'b0;
        end else if (kill_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            s1_op32    <= req_i.op_32;
            s1_neg     <= neg1 ^ neg2;
            s1_high    <= (req_i.op != OP_MUL);
            s1_tag     <= req_i.tag;
            src1_mag_q <= src1_mag_d;
            src2_mag_q <= src2_mag_d;
        end
    end

    // Two 64 x 32 partial products
    assign pp_lo = src1_mag_q * src2_mag_q[WORD_W-1:0];
    assign pp_hi = src1_mag_q * src2_mag_q[XLEN-1:WORD_W];

    // MULW is done here, only the low word of pp_lo matters
    assign word_fix   = s1_neg ? ~pp_lo[WORD_W-1:0] + 1'b1 : pp_lo[WORD_W-1:0];
    assign word_res   = {{(XLEN-WORD_W){word_fix[WORD_W-1]}}, word_fix};
    assign word_valid = s1_valid && s1_op32;

    // ----------------------------------------
    // Stage two
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s2_valid <= 1'b0;
        end else if (kill_i) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid && !s1_op32;  // Word ops leave at stage one
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid && !s1_op32) begin
            s2_neg  <= s1_neg;
            s2_high <= s1_high;
            s2_tag  <= s1_tag;
            pp_lo_q <= pp_lo;
            pp_hi_q <= pp_hi;
        end
    end

    assign prod     = {{(PROD_W-PP_W){1'b0}}, pp_lo_q} + {pp_hi_q, {WORD_W{1'b0}}};
    assign prod_fix = s2_neg ? ~prod + 1'b1 : prod;
    assign long_res = s2_high ? prod_fix[PROD_W-1:XLEN] : prod_fix[XLEN-1:0];

    // Issue control keeps the two result paths from colliding
    always_comb begin
        if (word_valid) begin
            wb_o.valid  = 1'b1;
            wb_o.tag    = s1_tag;
            wb_o.result = word_res;
        end else begin
            wb_o.valid  = s2_valid;
            wb_o.tag    = s2_tag;
            wb_o.result = long_res;
        end
    end

endmodule

//--- logic/exe_wb.sv
`timescale 1ns/100ps

module exe_wb import exe_pkg::*; (
    input  logic  clk_i,
    input  logic  rstn_i,
    input  logic  kill_i,
    input  wb_t   alu_wb_i,
    input  wb_t   mul_wb_i,
    output logic  wb_valid_o,
    output tag_t  wb_tag_o,
    output xlen_t wb_result_o
);

    logic  valid_q;
    tag_t  tag_q;
    xlen_t result_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else if (kill_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= alu_wb_i.valid || mul_wb_i.valid;
        end
    end

    // At most one unit result is valid per cycle
    always_ff @(posedge clk_i) begin
        if (alu_wb_i.valid) begin
            tag_q    <= alu_wb_i.tag;
            result_q <= alu_wb_i.result;
        end else if (mul_wb_i.valid) begin
            tag_q    <= mul_wb_i.tag;
            result_q <= mul_wb_i.result;
        end
    end

    assign wb_valid_o  = valid_q;
    assign wb_tag_o    = tag_q;
    assign wb_result_o = result_q;

endmodule

//--- logic/exe_top.sv
`timescale 1ns/100ps

module exe_top import exe_pkg::*; (
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    kill_i,
    // Issue port
    input  logic    issue_valid_i,
    input  exe_op_t issue_op_i,
    input  logic    issue_op32_i,
    input  xlen_t   issue_src1_i,
    input  xlen_t   issue_src2_i,
    input  tag_t    issue_tag_i,
    output logic    issue_ready_o,
    // Writeback port
    output logic    wb_valid_o,
    output tag_t    wb_tag_o,
    output xlen_t   wb_result_o
);

    exe_req_if alu_req ();
    exe_req_if mul_req ();

    wb_t alu_wb;
    wb_t mul_wb;

    issue_ctrl u_issue_ctrl (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .kill_i        (kill_i),
        .issue_valid_i (issue_valid_i),
        .issue_op_i    (issue_op_i),
        .issue_op32_i  (issue_op32_i),
        .issue_src1_i  (issue_src1_i),
        .issue_src2_i  (issue_src2_i),
        .issue_tag_i   (issue_tag_i),
        .issue_ready_o (issue_ready_o),
        .alu_req       (alu_req.issue),
        .mul_req       (mul_req.issue)
    );

    alu_unit u_alu_unit (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .kill_i (kill_i),
        .req_i  (alu_req.unit),
        .wb_o   (alu_wb)
    );

    mul_unit u_mul_unit (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .kill_i (kill_i),
        .req_i  (mul_req.unit),
        .wb_o   (mul_wb)
    );

    exe_wb u_exe_wb (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .kill_i      (kill_i),
        .alu_wb_i    (alu_wb),
        .mul_wb_i    (mul_wb),
        .wb_valid_o  (wb_valid_o),
        .wb_tag_o    (wb_tag_o),
        .wb_result_o (wb_result_o)
    );

endmodule

//--- verification/exe_vectors.svh
`ifndef EXE_VECTORS_SVH
`define EXE_VECTORS_SVH

    localparam int NUM_DIRECTED = 33;

    // Columns are op, word flag, src1, src2, idle cycles after the row, kill after acceptance
    vec_t directed_rows [NUM_DIRECTED] = '{
        // ALU and W forms with overflow at both widths
        '{OP_ADD,    1'b0, 64'h0000_0000_0000_0007, 64'h0000_0000_0000_0005, 4'd1, 1'b0},
        '{OP_ADD,    1'b0, 64'hffff_ffff_ffff_ffff, 64'h0000_0000_0000_0001, 4'd0, 1'b0},
        '{OP_SUB,    1'b0, 64'h0000_0000_0000_0000, 64'h0000_0000_0000_0001, 4'd0, 1'b0},
        '{OP_SUB,    1'b0, 64'h8000_0000_0000_0000, 64'h0000_0000_0000_0001, 4'd1, 1'b0},
        '{OP_AND,    1'b0, 64'hf0f0_f0f0_0f0f_0f0f, 64'h0ff0_0ff0_0ff0_0ff0, 4'd0, 1'b0},
        '{OP_OR,     1'b0, 64'hf0f0_f0f0_0f0f_0f0f, 64'h0ff0_0ff0_0ff0_0ff0, 4'd0, 1'b0},
        '{OP_XOR,    1'b0, 64'hf0f0_f0f0_0f0f_0f0f, 64'hffff_ffff_ffff_ffff, 4'd2, 1'b0},
        '{OP_ADD,    1'b1, 64'h0000_0000_7fff_ffff, 64'h0000_0000_0000_0001, 4'd0, 1'b0},
        '{OP_SUB,    1'b1, 64'h1234_5678_0000_0000, 64'h0000_0000_0000_0001, 4'd0, 1'b0},
        '{OP_ADD,    1'b1, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_0000_0001, 4'd2, 1'b0},
        // Multiplies on edge operands with idle gaps
        '{OP_MUL,    1'b0, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 4'd2, 1'b0},
        '{OP_MUL,    1'b0, 64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff, 4'd2, 1'b0},
        '{OP_MULH,   1'b0, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 4'd2, 1'b0},
        '{OP_MULH,   1'b0, 64'hffff_ffff_ffff_ffff, 64'h0000_0000_0000_0001, 4'd2, 1'b0},
        '{OP_MULHSU, 1'b0, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 4'd2, 1'b0},
        '{OP_MULHSU, 1'b0, 64'h8000_0000_0000_0000, 64'h0000_0000_0000_0002, 4'd2, 1'b0},
        '{OP_MULHU,  1'b0, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 4'd2, 1'b0},
        '{OP_MULHU,  1'b0, 64'h0000_0000_0000_0000, 64'hffff_ffff_ffff_ffff, 4'd2, 1'b0},
        '{OP_MUL,    1'b1, 64'h0000_0000_8000_0000, 64'hffff_ffff_ffff_ffff, 4'd0, 1'b0},
        '{OP_MUL,    1'b1, 64'habcd_0000_7fff_ffff, 64'h0000_0000_0000_0002, 4'd2, 1'b0},
        // Back to back stream where short ops behind long ones stall once
        '{OP_MUL,    1'b0, 64'h1234_5678_9abc_def0, 64'h0fed_cba9_8765_4321, 4'd0, 1'b0},
        '{OP_ADD,    1'b0, 64'h0000_0000_0000_1000, 64'h0000_0000_0000_0234, 4'd0, 1'b0},
        '{OP_MULH,   1'b0, 64'hfedc_ba98_7654_3210, 64'h0123_4567_89ab_cdef, 4'd0, 1'b0},
        '{OP_MUL,    1'b1, 64'h0000_0000_ffff_fffe, 64'h0000_0000_0000_0003, 4'd0, 1'b0},
        '{OP_MULHU,  1'b0, 64'hdead_beef_cafe_f00d, 64'h8765_4321_0fed_cba9, 4'd0, 1'b0},
        '{OP_MULHSU, 1'b0, 64'h8000_0000_0000_0001, 64'hffff_0000_ffff_0000, 4'd0, 1'b0},
        '{OP_SUB,    1'b0, 64'h0000_0000_0000_0010, 64'h0000_0000_0000_0020, 4'd0, 1'b0},
        '{OP_ADD,    1'b1, 64'h0000_0000_8000_0000, 64'h0000_0000_8000_0000, 4'd2, 1'b0},
        // Kill with results in flight and normal traffic after it
        '{OP_MULH,   1'b0, 64'h0000_0000_0000_0111, 64'h0000_0000_0000_0222, 4'd0, 1'b0},
        '{OP_MUL,    1'b0, 64'h0000_0000_0000_0003, 64'h0000_0000_0000_0004, 4'd0, 1'b1},
        '{OP_ADD,    1'b0, 64'h0000_0000_0000_0005, 64'h0000_0000_0000_0006, 4'd0, 1'b0},
        '{OP_SUB,    1'b1, 64'h0000_0000_0000_0007, 64'h0000_0000_0000_0008, 4'd1, 1'b1},
        '{OP_XOR,    1'b0, 64'haaaa_aaaa_aaaa_aaaa, 64'h5555_5555_5555_5555, 4'd2, 1'b0}
    };

`endif

//--- verification/tb_exe_top.sv
`timescale 1ns/100ps

module tb_exe_top import exe_pkg::*; ();

    // ----------------------------------------
    // Setup
    // ----------------------------------------
    localparam int DRV_DLY      = 2;  // Inputs change after the rising edge
    localparam int RST_CYCLES   = 3;
    localparam int SHORT_LAT    = 2;
    localparam int LONG_LAT     = 3;
    localparam int NUM_RANDOM   = 64;
    localparam int DRAIN_CYCLES = 8;

    typedef struct packed {
        exe_op_t    op;
        logic       op32;
        xlen_t      src1;
        xlen_t      src2;
        logic [3:0] gap;   // Idle cycles after the row
        logic       kill;  // Kill in the cycle after acceptance
    } vec_t;

    typedef struct {
        xlen_t result;
        tag_t  tag;
        int    due;    // Cycle count while the result is on the port
        string name;
    } exp_t;

    `include "exe_vectors.svh"

    localparam int TIMEOUT_CYCLES = 4 * (NUM_DIRECTED + NUM_RANDOM) + 50;

    logic    clk;
    logic    rstn;
    logic    kill;
    logic    issue_valid;
    exe_op_t issue_op;
    logic    issue_op32;
    xlen_t   issue_src1;
    xlen_t   issue_src2;
    tag_t    issue_tag;
    logic    issue_ready;
    logic    wb_valid;
    tag_t    wb_tag;
    xlen_t   wb_result;

    exp_t        exp_q[$];
    int          cyc = 0;
    int          cur_row = 0;
    logic        prev_long = 1'b0;  // Long multiply taken at the last edge
    logic [31:0] rng = 32'ha842_efb9;
    exe_op_t     op_list [9] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                 OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};

    exe_top uut (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .kill_i        (kill),
        .issue_valid_i (issue_valid),
        .issue_op_i    (issue_op),
        .issue_op32_i  (issue_op32),
        .issue_src1_i  (issue_src1),
        .issue_src2_i  (issue_src2),
        .issue_tag_i   (issue_tag),
        .issue_ready_o (issue_ready),
        .wb_valid_o    (wb_valid),
        .wb_tag_o      (wb_tag),
        .wb_result_o   (wb_result)
    );

    always #10 clk = ~clk;

    // ----------------------------------------
    // Reference model and checks
    // ----------------------------------------
    function automatic logic long_mul(input exe_op_t op, input logic op32);
        case (op)
            OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: return !op32;
            default:                              return 1'b0;
        endcase
    endfunction

    function automatic xlen_t ref_result(input exe_op_t op, input logic op32,
                                         input xlen_t a, input xlen_t b);
        logic [2*XLEN-1:0] sa;
        logic [2*XLEN-1:0] sb;
        logic [2*XLEN-1:0] ua;
        logic [2*XLEN-1:0] ub;
        logic [2*XLEN-1:0] p;
        xlen_t             r;
        sa = {{XLEN{a[XLEN-1]}}, a};
        sb = {{XLEN{b[XLEN-1]}}, b};
        ua = {{XLEN{1'b0}}, a};
        ub = {{XLEN{1'b0}}, b};
        p  = '0;
        case (op)
            OP_ADD:    r = a + b;
            OP_SUB:    r = a - b;
            OP_AND:    r = a & b;
            OP_OR:     r = a | b;
            OP_XOR:    r = a ^ b;
            OP_MUL:    p = sa * sb;
            OP_MULH:   p = sa * sb;
            OP_MULHSU: p = sa * ub;
            default:   p = ua * ub;
        endcase
        if (op == OP_MUL) r = p[XLEN-1:0];
        else if (op inside {OP_MULH, OP_MULHSU, OP_MULHU}) r = p[2*XLEN-1:XLEN];
        if (op32) r = {{32{r[31]}}, r[31:0]};  // W forms
        return r;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input xlen_t want, input xlen_t got);
        if (got !== want) begin
            $display("error %s result: expected %h, actual %h", name, want, got);
            stop_run("result mismatch");
        end
    endtask

    task automatic check_tag(input string name, input tag_t want, input tag_t got);
        if (got !== want) begin
            $display("error %s tag: expected %0d, actual %0d", name, want, got);
            stop_run("tag mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic want, input logic got);
        if (got !== want) begin
            $display("error %s: expected %b, actual %b", name, want, got);
            stop_run("handshake mismatch");
        end
    endtask

    task automatic check_cycle(input string name, input int want, input int got);
        if (got != want) begin
            $display("error %s writeback cycle: expected %0d, actual %0d", name, want, got);
            stop_run("writeback at the wrong cycle");
        end
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            stop_run($sformatf("timeout after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // Outputs are sampled mid cycle
    always @(negedge clk) begin : monitor
        exp_t e;
        logic cur_long;
        cur_long = long_mul(issue_op, issue_op32);
        if (rstn) begin
            check_flag($sformatf("issue_ready at cycle %0d", cyc),
                       !kill && !(prev_long && !cur_long), issue_ready);
            if (wb_valid) begin
                if (exp_q.size() == 0) begin
                    stop_run("writeback valid with no result outstanding");
                end else begin
                    e = exp_q.pop_front();
                    check_cycle(e.name, e.due, cyc);
                    check_tag(e.name, e.tag, wb_tag);
                    check_result(e.name, e.result, wb_result);
                end
            end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
                stop_run($sformatf("no writeback for %s", exp_q[0].name));
            end
            // Kill at the next edge drops all that is still in flight
            if (kill) begin
                while (exp_q.size() != 0 && exp_q[$].due > cyc) begin
                    void'(exp_q.pop_back());
                end
            end
            if (issue_valid && issue_ready) begin
                e.result = ref_result(issue_op, issue_op32, issue_src1, issue_src2);
                e.tag    = issue_tag;
                e.due    = cyc + 1 + (cur_long ? LONG_LAT : SHORT_LAT);
                e.name   = $sformatf("row %0d %s%s", cur_row, issue_op.name(),
                                     issue_op32 ? "W" : "");
                exp_q.push_back(e);
            end
            prev_long = issue_valid && issue_ready && cur_long;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic make_random_row(output vec_t v);
        int k;
        rng    = xorshift(rng);
        k      = int'(rng % 32'd9);
        v.op   = op_list[k];
        v.op32 = rng[20] && (v.op inside {OP_ADD, OP_SUB, OP_MUL});  // W forms exist only here
        rng    = xorshift(rng);
        v.src1[63:32] = rng;
        rng    = xorshift(rng);
        v.src1[31:0]  = rng;
        rng    = xorshift(rng);
        v.src2[63:32] = rng;
        rng    = xorshift(rng);
        v.src2[31:0]  = rng;
        rng    = xorshift(rng);
        v.gap  = 4'(rng % 32'd3);
        v.kill = 1'b0;
    endtask

    // Holds the row on the port until it is taken
    task automatic apply_row(input vec_t v, input int row);
        logic took;
        cur_row     = row;
        issue_valid = 1'b1;
        issue_op    = v.op;
        issue_op32  = v.op32;
        issue_src1  = v.src1;
        issue_src2  = v.src2;
        issue_tag   = tag_t'(row);
        do begin
            @(negedge clk);
            took = issue_ready;
            @(posedge clk);
            #DRV_DLY;
        end while (!took);
        issue_valid = 1'b0;
        if (v.kill) begin
            kill = 1'b1;
            @(posedge clk);
            #DRV_DLY;
            kill = 1'b0;
        end
        repeat (v.gap) begin
            @(posedge clk);
            #DRV_DLY;
        end
    endtask

    initial begin
        vec_t v;
        clk         = 1'b0;
        rstn        = 1'b0;
        kill        = 1'b0;
        issue_valid = 1'b0;
        issue_op    = OP_ADD;
        issue_op32  = 1'b0;
        issue_src1  = '0;
        issue_src2  = '0;
        issue_tag   = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRV_DLY;
        rstn = 1'b1;
        for (int i = 0; i < NUM_DIRECTED; i++) begin
            apply_row(directed_rows[i], i);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            make_random_row(v);
            apply_row(v, NUM_DIRECTED + i);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_run($sformatf("%0d results never reached writeback", exp_q.size()));
        end
    end

endmodule

//--- files.f
+incdir+verification
logic/exe_pkg.sv
logic/exe_req_if.sv
logic/issue_ctrl.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/exe_wb.sv
logic/exe_top.sv
verification/tb_exe_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
TOP       = tb_exe_top
FILELIST  = files.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep '\.sv$$' $(FILELIST)) $(wildcard verification/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep "Test completed successfully" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
